// File: design/alu_control.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module alu_control import id_pkg::*; (
    input  logic [`INSTR_WIDTH-1:0] instr,
    output alu_mode_e               control,
    output alu_sel_e                select
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    // Bit 30 only selects SUB for register-register ops.
    assign alt    = (opcode == OP) && instr[30];

    always_comb begin
        // Loads, stores, upper immediates and jumps compute an address.
        control = MODE_ADD;
        select  = ADD;
        case (opcode)
            BRANCH: begin
                control = MODE_BRANCH;
                select  = SUB;
            end
            OP, OP_IMM: begin
                control = MODE_FUNCT;
                case (funct3)
                    3'b000: select = alt ? SUB : ADD;
                    3'b001: select = SLL;
                    3'b010: select = SLT;
                    3'b011: select = SLT;
                    3'b100: select = XOR;
                    // Shift type comes from instr[30] in execute.
                    3'b101: select = SRL;
                    3'b110: select = OR;
                    default: select = AND;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: design/fpu_control.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module fpu_control import id_pkg::*; (
    input  logic [`INSTR_WIDTH-1:0] instr,
    output logic                    fpu_rs1,
    output logic                    fpu_rd,
    output fpu_op_e                 fpu_op
);

    opcode_e    opcode;
    logic [4:0] funct5;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct5 = instr[31:27];

    always_comb begin
        fpu_rs1 = 1'b0;
        fpu_rd  = 1'b0;
        fpu_op  = FADD;
        case (opcode)
            OP_FP: begin
                fpu_rs1 = 1'b1;
                fpu_rd  = 1'b1;
                case (funct5)
                    5'b00000: fpu_op = FADD;
                    5'b00001: fpu_op = FSUB;
                    5'b00010: fpu_op = FMUL;
                    5'b00011: fpu_op = FDIV;
                    5'b00100: fpu_op = FSGNJ;
                    5'b00101: fpu_op = FMINMAX;
                    // Compare and move to integer write an integer rd.
                    5'b10100: begin
                        fpu_op = FCMP;
                        fpu_rd = 1'b0;
                    end
                    5'b11100: begin
                        fpu_op = FMV;
                        fpu_rd = 1'b0;
                    end
                    // Move from integer reads an integer rs1.
                    5'b11110: begin
                        fpu_op  = FMV;
                        fpu_rs1 = 1'b0;
                    end
                    default: fpu_op = FADD;
                endcase
            end
            LOAD_FP: fpu_rd = 1'b1;
            default: ;
        endcase
    end

    a_fpu_idle: assert property (@(instr) (opcode != OP_FP) |-> (fpu_op == FADD));

endmodule

// File: design/id_defs.svh
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// Data path and register file widths.
`define BUS_WIDTH 64

`define INSTR_WIDTH 32

// One bank bit on top of the 5-bit instruction field.
`define REGFILE_LEN 6

`define REG_COUNT 64

`endif

// File: design/id_pkg.sv
package id_pkg;

    // Major opcodes, instr[6:0].
    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        LOAD_FP  = 7'b0000111,
        OP_IMM   = 7'b0010011,
        AUIPC    = 7'b0010111,
        STORE    = 7'b0100011,
        STORE_FP = 7'b0100111,
        OP       = 7'b0110011,
        LUI      = 7'b0110111,
        OP_FP    = 7'b1010011,
        BRANCH   = 7'b1100011,
        JALR     = 7'b1100111,
        JAL      = 7'b1101111
    } opcode_e;

    typedef enum logic [1:0] {
        MODE_ADD    = 2'd0,
        MODE_BRANCH = 2'd1,
        MODE_FUNCT  = 2'd2
    } alu_mode_e;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_sel_e;

    typedef enum logic [2:0] {
        FADD    = 3'd0,
        FSUB    = 3'd1,
        FMUL    = 3'd2,
        FDIV    = 3'd3,
        FMINMAX = 3'd4,
        FSGNJ   = 3'd5,
        FCMP    = 3'd6,
        FMV     = 3'd7
    } fpu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } branch_e;

endpackage

// File: design/id_stage.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_stage import id_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  logic [`INSTR_WIDTH-1:0] instr,

    // Write-back port.
    input  logic                    wb_reg_write,
    input  logic [`REGFILE_LEN-1:0] wb_rd,
    input  logic [`BUS_WIDTH-1:0]   write_data,

    output logic                    reg_write,
    output logic                    mem_write,
    output logic                    mem_read,
    output logic                    mem_to_reg,
    output logic                    jump_src,
    output logic                    jalr_src,
    output logic                    u_src,
    output logic                    uj_src,
    output logic                    alu_src,
    output logic                    alu_fpu,
    output branch_e                 branch_src,

    output alu_mode_e               control,
    output alu_sel_e                select,

    output logic                    fpu_rd,
    output fpu_op_e                 fpu_op,

    output logic [`BUS_WIDTH-1:0]   read_data1,
    output logic [`BUS_WIDTH-1:0]   read_data2,
    output logic [`REGFILE_LEN-1:0] rd,
    output logic [`BUS_WIDTH-1:0]   imm
);

    logic                    fpu_rs1;
    logic [`REGFILE_LEN-1:0] rs1;
    logic [`REGFILE_LEN-1:0] rs2;
    logic                    rf_write;

    main_control u_main_control (
        .instr      (instr),
        .reg_write  (reg_write),
        .mem_write  (mem_write),
        .mem_read   (mem_read),
        .mem_to_reg (mem_to_reg),
        .jump_src   (jump_src),
        .jalr_src   (jalr_src),
        .u_src      (u_src),
        .uj_src     (uj_src),
        .alu_src    (alu_src),
        .alu_fpu    (alu_fpu),
        .branch_src (branch_src)
    );

    alu_control u_alu_control (
        .instr   (instr),
        .control (control),
        .select  (select)
    );

    fpu_control u_fpu_control (
        .instr   (instr),
        .fpu_rs1 (fpu_rs1),
        .fpu_rd  (fpu_rd),
        .fpu_op  (fpu_op)
    );

    // The bank bit sits on top. rs2 of an FP instruction is always an FP register.
    assign rs1 = {alu_fpu & fpu_rs1, instr[19:15]};
    assign rs2 = {alu_fpu, instr[24:20]};
    assign rd  = {alu_fpu & fpu_rd, instr[11:7]};

    // Stalled write-backs are dropped.
    assign rf_write = wb_reg_write & ~stall;

    regfile u_regfile (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_enable (rf_write),
        .read_addr1   (rs1),
        .read_addr2   (rs2),
        .write_addr   (wb_rd),
        .write_data   (write_data),
        .read_data1   (read_data1),
        .read_data2   (read_data2)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

endmodule

// File: design/imm_gen.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module imm_gen import id_pkg::*; (
    input  logic [`INSTR_WIDTH-1:0] instr,
    output logic [`BUS_WIDTH-1:0]   imm
);

    opcode_e opcode;
    logic    sign;

    assign opcode = opcode_e'(instr[6:0]);
    assign sign   = instr[31];

    always_comb begin
        case (opcode)
            LOAD, LOAD_FP, OP_IMM, JALR: begin
                imm = {{(`BUS_WIDTH-12){sign}}, instr[31:20]};
            end
            STORE, STORE_FP: begin
                imm = {{(`BUS_WIDTH-12){sign}}, instr[31:25], instr[11:7]};
            end
            BRANCH: begin
                imm = {{(`BUS_WIDTH-13){sign}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            // Upper immediate sits in bits 31:12.
            LUI, AUIPC: begin
                imm = {{(`BUS_WIDTH-32){sign}}, instr[31:12], 12'b0};
            end
            JAL: begin
                imm = {{(`BUS_WIDTH-21){sign}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// File: design/main_control.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module main_control import id_pkg::*; (
    input  logic [`INSTR_WIDTH-1:0] instr,
    output logic                    reg_write,
    output logic                    mem_write,
    output logic                    mem_read,
    output logic                    mem_to_reg,
    output logic                    jump_src,
    output logic                    jalr_src,
    output logic                    u_src,
    output logic                    uj_src,
    output logic                    alu_src,
    output logic                    alu_fpu,
    output branch_e                 branch_src
);

    opcode_e    opcode;
    logic [2:0] funct3;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];

    always_comb begin
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        mem_read   = 1'b0;
        mem_to_reg = 1'b0;
        jump_src   = 1'b0;
        jalr_src   = 1'b0;
        u_src      = 1'b0;
        uj_src     = 1'b0;
        alu_src    = 1'b0;
        alu_fpu    = 1'b0;
        branch_src = BR_NONE;
        case (opcode)
            LOAD, LOAD_FP: begin
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                alu_src    = 1'b1;
                alu_fpu    = (opcode == LOAD_FP);
            end
            STORE, STORE_FP: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                alu_fpu   = (opcode == STORE_FP);
            end
            OP_IMM: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            OP: begin
                reg_write = 1'b1;
            end
            LUI, AUIPC: begin
                reg_write = 1'b1;
                u_src     = 1'b1;
                alu_src   = 1'b1;
            end
            OP_FP: begin
                reg_write = 1'b1;
                alu_fpu   = 1'b1;
            end
            BRANCH: begin
                case (funct3)
                    3'b000:  branch_src = BR_EQ;
                    3'b001:  branch_src = BR_NE;
                    3'b100:  branch_src = BR_LT;
                    3'b101:  branch_src = BR_GE;
                    3'b110:  branch_src = BR_LTU;
                    3'b111:  branch_src = BR_GEU;
                    default: branch_src = BR_NONE;
                endcase
            end
            JALR: begin
                reg_write = 1'b1;
                jump_src  = 1'b1;
                jalr_src  = 1'b1;
                alu_src   = 1'b1;
            end
            JAL: begin
                reg_write = 1'b1;
                jump_src  = 1'b1;
                uj_src    = 1'b1;
            end
            default: ;
        endcase
    end

    // A memory access is either a read or a write.
    a_mem_excl: assert property (@(instr) mem_read |-> !mem_write);

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    write_enable,
    input  logic [`REGFILE_LEN-1:0] read_addr1,
    input  logic [`REGFILE_LEN-1:0] read_addr2,
    input  logic [`REGFILE_LEN-1:0] write_addr,
    input  logic [`BUS_WIDTH-1:0]   write_data,
    output logic [`BUS_WIDTH-1:0]   read_data1,
    output logic [`BUS_WIDTH-1:0]   read_data2
);

    // Entries 0-31 are the integer bank, 32-63 the floating-point bank.
    logic [`BUS_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_addr != '0)) begin
            // Only x0 is hardwired; f0 at address 32 is writable.
            regs[write_addr] <= write_data;
        end
    end

    // There is no bypass. A same-cycle write is seen from the next cycle.
    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0);

endmodule

// File: dv/id_stage_tb.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_stage_tb import id_pkg::*; ();

    // Well above the few hundred cycles that the tests take.
    localparam int MAX_CYCLES = 2000;

    localparam int FMT_R = 0;
    localparam int FMT_I = 1;
    localparam int FMT_S = 2;
    localparam int FMT_B = 3;
    localparam int FMT_U = 4;
    localparam int FMT_J = 5;

    logic                    clk;
    logic                    rst_n;
    logic                    stall;
    logic [`INSTR_WIDTH-1:0] instr;
    logic                    wb_reg_write;
    logic [`REGFILE_LEN-1:0] wb_rd;
    logic [`BUS_WIDTH-1:0]   write_data;
    logic                    reg_write, mem_write, mem_read, mem_to_reg, jump_src;
    logic                    jalr_src, u_src, uj_src, alu_src, alu_fpu;
    branch_e                 branch_src;
    alu_mode_e               control;
    alu_sel_e                select;
    logic                    fpu_rd;
    fpu_op_e                 fpu_op;
    logic [`BUS_WIDTH-1:0]   read_data1;
    logic [`BUS_WIDTH-1:0]   read_data2;
    logic [`REGFILE_LEN-1:0] rd;
    logic [`BUS_WIDTH-1:0]   imm;

    // Expected register contents.
    logic [`BUS_WIDTH-1:0]   model [`REG_COUNT];
    logic [15:0]             lfsr;
    int                      cycles = 0;
    int                      errors = 0;
    int                      checks = 0;
    int                      tests = 0;
    int                      mark;

    id_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [63:0] sext(input logic [63:0] v, input int bits);
        logic signed [63:0] s;
        s = v << (64 - bits);
        return s >>> (64 - bits);
    endfunction

    function automatic logic [31:0] encode(input int fmt, input logic [6:0] op,
                                           input logic [2:0] f3, input logic [6:0] f7,
                                           input logic [4:0] rdf, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [31:0] im);
        case (fmt)
            FMT_I:   return {im[11:0], rs1, f3, rdf, op};
            FMT_S:   return {im[11:5], rs2, rs1, f3, im[4:0], op};
            FMT_B:   return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], op};
            FMT_U:   return {im[31:12], rdf, op};
            FMT_J:   return {im[20], im[10:1], im[11], im[19:12], rdf, op};
            default: return {f7, rs2, rs1, f3, rdf, op};
        endcase
    endfunction

    // OP reads the integer bank on both ports, FADD the FP bank.
    function automatic logic [31:0] read_instr(input logic [5:0] addr);
        return encode(FMT_R, addr[5] ? OP_FP : OP, 3'b000, 7'd0, 5'd1,
                      addr[4:0], addr[4:0], 32'd0);
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic report(input string name, input int errs_before);
        tests++;
        $display("Test %-16s done, %0d errors", name, errors - errs_before);
    endtask

    task automatic read_back(input logic [5:0] addr);
        tick();
        instr = read_instr(addr);
        #1;
        check("read_data1", read_data1, model[addr]);
        check("read_data2", read_data2, model[addr]);
    endtask

    // A read in the write cycle still sees the old value.
    task automatic write_reg(input logic [5:0] addr, input logic [63:0] data, input logic hold);
        tick();
        stall = hold;
        wb_reg_write = 1'b1;
        wb_rd = addr;
        write_data = data;
        instr = read_instr(addr);
        #1;
        check("read_data1", read_data1, model[addr]);
        tick();
        wb_reg_write = 1'b0;
        stall = 1'b0;
        if (!hold && addr != 6'd0) begin
            model[addr] = data;
        end
        // The new value shows in the cycle right after the write edge.
        #1;
        check("read_data2", read_data2, model[addr]);
    endtask

    task automatic expect_ctrl(input logic [6:0] op, input logic [2:0] f3, input logic [6:0] f7,
                               input logic [9:0] bits, input branch_e br, input alu_mode_e mode,
                               input alu_sel_e sel);
        tick();
        instr = encode(FMT_R, op, f3, f7, 5'(lfsr_bits(5)), 5'(lfsr_bits(5)),
                       5'(lfsr_bits(5)), 32'd0);
        #1;
        check("controls", {reg_write, mem_write, mem_read, mem_to_reg, jump_src, jalr_src,
                           u_src, uj_src, alu_src, alu_fpu}, bits);
        check("branch_src", branch_src, br);
        check("control", control, mode);
        check("select", select, sel);
    endtask

    task automatic expect_banks(input logic [31:0] x, input logic rs1_bank, input logic rd_bank,
                                input fpu_op_e op);
        tick();
        instr = x;
        #1;
        check("rd", rd, {rd_bank, x[11:7]});
        check("fpu_rd", fpu_rd, rd_bank);
        check("fpu_op", fpu_op, op);
        check("read_data1", read_data1, model[{rs1_bank, x[19:15]}]);
        // rs2 of every FP extension opcode is an FP register.
        check("read_data2", read_data2, model[{1'b1, x[24:20]}]);
    endtask

    task automatic reset_values();
        for (int a = 0; a < `REG_COUNT; a++) begin
            read_back(6'(a));
        end
    endtask

    task automatic write_then_read();
        logic [5:0] addr;
        for (int i = 0; i < 20; i++) begin
            addr = 6'(lfsr_bits(6));
            write_reg(addr, lfsr_bits(64), 1'b0);
            read_back(addr);
        end
        write_reg(6'd0, 64'hdead_beef_0000_0001, 1'b0);
        read_back(6'd0);
        write_reg(6'd32, 64'h0123_4567_89ab_cdef, 1'b0);
        read_back(6'd32);
    endtask

    task automatic stalled_write();
        logic [63:0] data;
        data = lfsr_bits(64);
        write_reg(6'd45, data, 1'b1);
        read_back(6'd45);
        write_reg(6'd45, data, 1'b0);
        read_back(6'd45);
    endtask

    task automatic control_table();
        logic [2:0] br_f3 [6];
        branch_e    br_exp [6];
        br_f3  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        br_exp = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
        expect_ctrl(LOAD,     3'b011, 7'd0, 10'b1011000010, BR_NONE, MODE_ADD, ADD);
        expect_ctrl(LOAD_FP,  3'b011, 7'd0, 10'b1011000011, BR_NONE, MODE_ADD, ADD);
        expect_ctrl(STORE,    3'b011, 7'd0, 10'b0100000010, BR_NONE, MODE_ADD, ADD);
        expect_ctrl(STORE_FP, 3'b011, 7'd0, 10'b0100000011, BR_NONE, MODE_ADD, ADD);
        // Bit 30 of OP_IMM is immediate data.
        expect_ctrl(OP_IMM, 3'b000, 7'b0100000, 10'b1000000010, BR_NONE, MODE_FUNCT, ADD);
        expect_ctrl(OP_IMM, 3'b100, 7'd0,       10'b1000000010, BR_NONE, MODE_FUNCT, XOR);
        expect_ctrl(OP,     3'b000, 7'b0100000, 10'b1000000000, BR_NONE, MODE_FUNCT, SUB);
        expect_ctrl(OP,     3'b110, 7'd0,       10'b1000000000, BR_NONE, MODE_FUNCT, OR);
        expect_ctrl(LUI,      3'b000, 7'd0, 10'b1000001010, BR_NONE, MODE_ADD, ADD);
        expect_ctrl(AUIPC,    3'b000, 7'd0, 10'b1000001010, BR_NONE, MODE_ADD, ADD);
        expect_ctrl(OP_FP,    3'b000, 7'd0, 10'b1000000001, BR_NONE, MODE_ADD, ADD);
        expect_ctrl(JALR,     3'b000, 7'd0, 10'b1000110010, BR_NONE, MODE_ADD, ADD);
        expect_ctrl(JAL,      3'b000, 7'd0, 10'b1000100100, BR_NONE, MODE_ADD, ADD);
        for (int i = 0; i < 6; i++) begin
            expect_ctrl(BRANCH, br_f3[i], 7'd0, 10'b0, br_exp[i], MODE_BRANCH, SUB);
        end
        expect_ctrl(7'b1111111, 3'b000, 7'd0, 10'b0, BR_NONE, MODE_ADD, ADD);
    endtask

    task automatic immediate_values();
        logic [6:0]  ops [10];
        int          widths [6];
        logic [63:0] raw;
        int          fmt;
        ops    = '{OP_IMM, STORE, BRANCH, LUI, JAL, JALR, STORE_FP, BRANCH, AUIPC, JAL};
        widths = '{0, 12, 12, 13, 32, 21};
        for (int i = 0; i < 30; i++) begin
            fmt = (i % 5) + 1;
            raw = lfsr_bits(32);
            // B and J offsets are even, U fills only the upper 20 bits.
            if (fmt == FMT_B || fmt == FMT_J) begin
                raw[0] = 1'b0;
            end
            if (fmt == FMT_U) begin
                raw[11:0] = '0;
            end
            tick();
            instr = encode(fmt, ops[i % 10], 3'(lfsr_bits(3)), 7'd0, 5'(lfsr_bits(5)),
                           5'(lfsr_bits(5)), 5'(lfsr_bits(5)), raw[31:0]);
            #1;
            check("imm", imm, sext(raw, widths[fmt]));
        end
    endtask

    task automatic operand_banks();
        write_reg(6'd5, lfsr_bits(64), 1'b0);
        write_reg(6'd37, lfsr_bits(64), 1'b0);
        write_reg(6'd6, lfsr_bits(64), 1'b0);
        write_reg(6'd38, lfsr_bits(64), 1'b0);
        expect_banks(encode(FMT_R, OP_FP, 3'b000, 7'b0000000, 5'd7, 5'd5, 5'd6, 32'd0),
                     1'b1, 1'b1, FADD);
        expect_banks(encode(FMT_R, OP_FP, 3'b010, 7'b1010000, 5'd7, 5'd5, 5'd6, 32'd0),
                     1'b1, 1'b0, FCMP);
        // Move from integer.
        expect_banks(encode(FMT_R, OP_FP, 3'b000, 7'b1111000, 5'd7, 5'd5, 5'd0, 32'd0),
                     1'b0, 1'b1, FMV);
        expect_banks(encode(FMT_I, LOAD_FP, 3'b011, 7'd0, 5'd7, 5'd5, 5'd0, 32'd6),
                     1'b0, 1'b1, FADD);
        expect_banks(encode(FMT_S, STORE_FP, 3'b011, 7'd0, 5'd0, 5'd5, 5'd6, 32'd7),
                     1'b0, 1'b0, FADD);
    endtask

    initial begin
        rst_n = 1'b0;
        stall = 1'b0;
        instr = '0;
        wb_reg_write = 1'b0;
        wb_rd = '0;
        write_data = '0;
        lfsr = 16'd34;
        for (int a = 0; a < `REG_COUNT; a++) begin
            model[a] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        mark = errors;
        reset_values();
        report("reset_values", mark);
        mark = errors;
        write_then_read();
        report("write_then_read", mark);
        mark = errors;
        stalled_write();
        report("stalled_write", mark);
        mark = errors;
        control_table();
        report("control_table", mark);
        mark = errors;
        immediate_values();
        report("immediate_values", mark);
        mark = errors;
        operand_banks();
        report("operand_banks", mark);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: id_stage.f
+incdir+design
design/id_pkg.sv
design/main_control.sv
design/alu_control.sv
design/fpu_control.sv
design/regfile.sv
design/imm_gen.sv
design/id_stage.sv
dv/id_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module id_stage_tb \
    -f id_stage.f -o sim_id_stage
./obj_dir/sim_id_stage | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
